// File: logic/decodePkg.sv
package decodePkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int OpcodeWidth  = 6;  // primary opcode and funct
    localparam int ShamtWidth   = 5;
    localparam int ImmWidth     = 16; // I-type immediate
    localparam int TargetWidth  = 26; // J-type target

    localparam logic [RegAddrWidth-1:0] LinkReg = 5'd31; // $ra

    typedef enum logic [OpcodeWidth-1:0] {
        opSpecial = 6'b000000,
        opRegimm  = 6'b000001,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddi    = 6'b001000,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opSltiu   = 6'b001011,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111,
        opLb      = 6'b100000,
        opLh      = 6'b100001,
        opLw      = 6'b100011,
        opLbu     = 6'b100100,
        opLhu     = 6'b100101,
        opSb      = 6'b101000,
        opSh      = 6'b101001,
        opSw      = 6'b101011
    } primaryOp_e;

    typedef enum logic [OpcodeWidth-1:0] {
        fnSll     = 6'b000000,
        fnSrl     = 6'b000010,
        fnSra     = 6'b000011,
        fnSllv    = 6'b000100,
        fnSrlv    = 6'b000110,
        fnSrav    = 6'b000111,
        fnJr      = 6'b001000,
        fnJalr    = 6'b001001,
        fnSyscall = 6'b001100,
        fnBreak   = 6'b001101,
        fnAdd     = 6'b100000,
        fnAddu    = 6'b100001,
        fnSub     = 6'b100010,
        fnSubu    = 6'b100011,
        fnAnd     = 6'b100100,
        fnOr      = 6'b100101,
        fnXor     = 6'b100110,
        fnNor     = 6'b100111,
        fnSlt     = 6'b101010,
        fnSltu    = 6'b101011
    } funct_e;

    // rt field of REGIMM
    typedef enum logic [RegAddrWidth-1:0] {
        riBltz   = 5'b00000,
        riBgez   = 5'b00001,
        riBltzal = 5'b10000,
        riBgezal = 5'b10001
    } regimmOp_e;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNor,
        aluXor,
        aluSlt,
        aluSltu,
        aluShiftLeft,
        aluShiftRight,
        aluShiftArith
    } aluOp_e;

    typedef enum logic [2:0] {
        cmpNone,
        cmpEqual,
        cmpNotEqual,
        cmpLessEqualZero,
        cmpGreaterZero,
        cmpLessZero,
        cmpGreaterEqualZero
    } cmpOp_e;

    typedef enum logic [1:0] {
        grfNone,
        grfAlu,
        grfMem,
        grfPc // return address for links
    } grfSrc_e;

    typedef enum logic [1:0] {
        memByte,
        memHalf,
        memWord
    } memWidth_e;

    typedef enum logic {
        jumpRegister,
        jumpImmediate
    } jumpSrc_e;

    typedef enum logic [1:0] {
        excNone,
        excSyscall,
        excBreak,
        excUnknownInstruction
    } exception_e;

    // all-zero value means no action in every field
    typedef struct packed {
        logic [RegAddrWidth-1:0] regRead1;
        logic [RegAddrWidth-1:0] regRead2;
        logic [RegAddrWidth-1:0] destReg;
        aluOp_e                  aluOp;
        logic                    aluSrc;        // immediate as second operand
        logic [DataWidth-1:0]    immediate;
        logic                    checkOverflow;
        grfSrc_e                 grfSrc;
        logic                    memLoad;
        logic                    memStore;
        memWidth_e               memWidth;
        logic                    memSignExtend;
        logic                    calcAddress;
        logic                    branch;
        cmpOp_e                  cmpOp;
        logic                    absJump;
        jumpSrc_e                jumpSrc;
        exception_e              exception;
    } controls_t;

    typedef struct packed {
        logic      hit;
        controls_t ctrl;
    } decodeResult_t;

    localparam controls_t NopControls = '0;

endpackage

// File: logic/specialDecoder.sv
`timescale 1ns/1ps

module specialDecoder (
    input  logic [decodePkg::DataWidth-1:0] instr,
    output decodePkg::decodeResult_t        result
);
    import decodePkg::*;

    primaryOp_e              opcode;
    funct_e                  funct;
    logic [RegAddrWidth-1:0] rs;
    logic [RegAddrWidth-1:0] rt;
    logic [RegAddrWidth-1:0] rd;
    logic [ShamtWidth-1:0]   shamt;
    logic                    hit;
    controls_t               ctrl;

    assign opcode = primaryOp_e'(instr[DataWidth-1 -: OpcodeWidth]);
    assign funct  = funct_e'(instr[OpcodeWidth-1:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];

    always_comb
    begin
        hit  = 1'b0;
        ctrl = NopControls;
        if (opcode == opSpecial)
        begin
            hit = 1'b1;
            case (funct)
                fnAddu, fnAdd, fnSubu, fnSub, fnAnd, fnOr, fnNor, fnXor, fnSlt, fnSltu:
                begin
                    ctrl.regRead1      = rs;
                    ctrl.regRead2      = rt;
                    ctrl.destReg       = rd;
                    ctrl.grfSrc        = grfAlu;
                    ctrl.checkOverflow = (funct == fnAdd) || (funct == fnSub); // trapping forms
                end
                fnSll, fnSrl, fnSra:
                begin
                    ctrl.regRead1  = rt;
                    ctrl.destReg   = rd;
                    ctrl.grfSrc    = grfAlu;
                    ctrl.aluSrc    = 1'b1;
                    ctrl.immediate = {{(DataWidth-ShamtWidth){1'b0}}, shamt};
                end
                fnSllv, fnSrlv, fnSrav:
                begin
                    ctrl.regRead1 = rt; // value to shift
                    ctrl.regRead2 = rs; // amount
                    ctrl.destReg  = rd;
                    ctrl.grfSrc   = grfAlu;
                end
                fnJr, fnJalr:
                begin
                    ctrl.regRead1 = rs;
                    ctrl.absJump  = 1'b1;
                    ctrl.jumpSrc  = jumpRegister;
                    if (funct == fnJalr)
                    begin
                        ctrl.destReg = rd;
                        ctrl.grfSrc  = grfPc;
                    end
                end
                fnSyscall: ctrl.exception = excSyscall;
                fnBreak:   ctrl.exception = excBreak;
                default:   hit = 1'b0; // mult, div, traps and unused codes
            endcase

            case (funct)
                fnSub, fnSubu:   ctrl.aluOp = aluSub;
                fnAnd:           ctrl.aluOp = aluAnd;
                fnOr:            ctrl.aluOp = aluOr;
                fnNor:           ctrl.aluOp = aluNor;
                fnXor:           ctrl.aluOp = aluXor;
                fnSlt:           ctrl.aluOp = aluSlt;
                fnSltu:          ctrl.aluOp = aluSltu;
                fnSll, fnSllv:   ctrl.aluOp = aluShiftLeft;
                fnSrl, fnSrlv:   ctrl.aluOp = aluShiftRight;
                fnSra, fnSrav:   ctrl.aluOp = aluShiftArith;
                default:         ctrl.aluOp = aluAdd;
            endcase

            if (!hit)
                ctrl = NopControls;
        end
    end

    assign result = '{hit: hit, ctrl: ctrl};

endmodule

// File: logic/immediateDecoder.sv
`timescale 1ns/1ps

module immediateDecoder (
    input  logic [decodePkg::DataWidth-1:0] instr,
    output decodePkg::decodeResult_t        result
);
    import decodePkg::*;

    primaryOp_e              opcode;
    logic [RegAddrWidth-1:0] rs;
    logic [RegAddrWidth-1:0] rt;
    logic [ImmWidth-1:0]     imm;
    logic [DataWidth-1:0]    signExtImm;
    logic [DataWidth-1:0]    zeroExtImm;
    logic [DataWidth-1:0]    shiftedImm;
    logic                    hit;
    controls_t               ctrl;

    assign opcode = primaryOp_e'(instr[DataWidth-1 -: OpcodeWidth]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign imm    = instr[ImmWidth-1:0];

    assign signExtImm = {{(DataWidth-ImmWidth){imm[ImmWidth-1]}}, imm};
    assign zeroExtImm = {{(DataWidth-ImmWidth){1'b0}}, imm};
    assign shiftedImm = {imm, {(DataWidth-ImmWidth){1'b0}}}; // lui

    always_comb
    begin
        hit  = 1'b1;
        ctrl = NopControls;
        ctrl.regRead1 = rs;
        case (opcode)
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui:
            begin
                ctrl.destReg       = rt;
                ctrl.grfSrc        = grfAlu;
                ctrl.aluSrc        = 1'b1;
                ctrl.checkOverflow = (opcode == opAddi);
                case (opcode)
                    opAndi, opOri, opXori: ctrl.immediate = zeroExtImm;
                    opLui:                 ctrl.immediate = shiftedImm;
                    default:               ctrl.immediate = signExtImm;
                endcase
                case (opcode)
                    opSlti:  ctrl.aluOp = aluSlt;
                    opSltiu: ctrl.aluOp = aluSltu;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    default: ctrl.aluOp = aluAdd; // addi, addiu, lui
                endcase
            end
            opLb, opLh, opLw, opLbu, opLhu:
            begin
                ctrl.memLoad       = 1'b1;
                ctrl.calcAddress   = 1'b1;
                ctrl.grfSrc        = grfMem;
                ctrl.destReg       = rt;
                ctrl.immediate     = signExtImm;
                ctrl.memSignExtend = (opcode == opLb) || (opcode == opLh);
                case (opcode)
                    opLb, opLbu: ctrl.memWidth = memByte;
                    opLh, opLhu: ctrl.memWidth = memHalf;
                    default:     ctrl.memWidth = memWord;
                endcase
            end
            opSb, opSh, opSw:
            begin
                ctrl.regRead2    = rt; // store data
                ctrl.memStore    = 1'b1;
                ctrl.calcAddress = 1'b1;
                ctrl.immediate   = signExtImm;
                case (opcode)
                    opSb:    ctrl.memWidth = memByte;
                    opSh:    ctrl.memWidth = memHalf;
                    default: ctrl.memWidth = memWord;
                endcase
            end
            default:
            begin
                hit  = 1'b0;
                ctrl = NopControls;
            end
        endcase
    end

    assign result = '{hit: hit, ctrl: ctrl};

endmodule

// File: logic/branchDecoder.sv
`timescale 1ns/1ps

module branchDecoder (
    input  logic [decodePkg::DataWidth-1:0] instr,
    output decodePkg::decodeResult_t        result
);
    import decodePkg::*;

    primaryOp_e              opcode;
    regimmOp_e               regimmOp;
    logic [RegAddrWidth-1:0] rs;
    logic [RegAddrWidth-1:0] rt;
    logic [DataWidth-1:0]    offset;
    logic [DataWidth-1:0]    target;
    logic                    hit;
    controls_t               ctrl;

    assign opcode   = primaryOp_e'(instr[DataWidth-1 -: OpcodeWidth]);
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign regimmOp = regimmOp_e'(rt);

    // word offset, the fetch side does the scaling
    assign offset = {{(DataWidth-ImmWidth){instr[ImmWidth-1]}}, instr[ImmWidth-1:0]};
    assign target = {{(DataWidth-TargetWidth){1'b0}}, instr[TargetWidth-1:0]};

    always_comb
    begin
        hit  = 1'b1;
        ctrl = NopControls;
        case (opcode)
            opBeq, opBne, opBlez, opBgtz:
            begin
                ctrl.regRead1  = rs;
                ctrl.branch    = 1'b1;
                ctrl.immediate = offset;
                case (opcode)
                    opBeq:   ctrl.cmpOp = cmpEqual;
                    opBne:   ctrl.cmpOp = cmpNotEqual;
                    opBlez:  ctrl.cmpOp = cmpLessEqualZero;
                    default: ctrl.cmpOp = cmpGreaterZero;
                endcase
                if (opcode == opBeq || opcode == opBne)
                    ctrl.regRead2 = rt;
            end
            opRegimm:
            begin
                ctrl.regRead1  = rs;
                ctrl.branch    = 1'b1;
                ctrl.immediate = offset;
                case (regimmOp)
                    riBltz, riBltzal: ctrl.cmpOp = cmpLessZero;
                    riBgez, riBgezal: ctrl.cmpOp = cmpGreaterEqualZero;
                    default:          hit = 1'b0; // likely forms, traps
                endcase
                if (regimmOp == riBltzal || regimmOp == riBgezal)
                begin
                    ctrl.destReg = LinkReg;
                    ctrl.grfSrc  = grfPc;
                end
            end
            opJ, opJal:
            begin
                ctrl.absJump   = 1'b1;
                ctrl.jumpSrc   = jumpImmediate;
                ctrl.immediate = target;
                if (opcode == opJal)
                begin
                    ctrl.destReg = LinkReg;
                    ctrl.grfSrc  = grfPc;
                end
            end
            default: hit = 1'b0;
        endcase

        if (!hit)
            ctrl = NopControls;
    end

    assign result = '{hit: hit, ctrl: ctrl};

endmodule

// File: logic/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [decodePkg::DataWidth-1:0] instr,
    input  logic                            instrValid,
    input  logic                            stall,
    output decodePkg::controls_t            controls
);
    import decodePkg::*;

    decodeResult_t specialRes;
    decodeResult_t immediateRes;
    decodeResult_t branchRes;
    controls_t     selected;

    specialDecoder specialDec (
        .instr  (instr),
        .result (specialRes)
    );

    immediateDecoder immediateDec (
        .instr  (instr),
        .result (immediateRes)
    );

    branchDecoder branchDec (
        .instr  (instr),
        .result (branchRes)
    );

    // decoders own disjoint encodings, at most one hit
    always_comb
    begin
        selected           = NopControls;
        selected.exception = excUnknownInstruction; // nobody claimed it
        if (specialRes.hit)
            selected = specialRes.ctrl;
        else if (immediateRes.hit)
            selected = immediateRes.ctrl;
        else if (branchRes.hit)
            selected = branchRes.ctrl;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            controls <= NopControls;
        else if (!stall)
            controls <= instrValid ? selected : NopControls; // bubble when no word
    end

endmodule

// File: testbench/decodeStage_checker.sv
`timescale 1ns/1ps

module decodeStage_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 instrValid,
    input logic                 stall,
    input decodePkg::controls_t controls
);
    import decodePkg::*;

    property nopAfterReset;
        @(posedge clk) rst |=> controls == NopControls;
    endproperty

    property holdOnStall;
        @(posedge clk) !rst && stall |=> $stable(controls);
    endproperty

    // no word offered, no stall
    property bubbleWhenIdle;
        @(posedge clk) !rst && !stall && !instrValid |=> controls == NopControls;
    endproperty

    resetNop: assert property (nopAfterReset)
        else $error("controls not cleared by reset");

    stallHold: assert property (holdOnStall)
        else $error("controls changed across a stalled edge");

    idleBubble: assert property (bubbleWhenIdle)
        else $error("missing nop bundle after an idle edge");

endmodule

bind decodeStage decodeStage_checker stageCheck (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .stall      (stall),
    .controls   (controls)
);

// File: testbench/decodeStage_tb.sv
`timescale 1ns/1ps

module decodeStage_tb;
    import decodePkg::*;

    localparam int ClkPeriod   = 10;
    localparam int ResetCycles = 4;
    localparam int ImmSign     = 0;
    localparam int ImmZero     = 1;
    localparam int ImmUpper    = 2;

    typedef struct {
        logic [DataWidth-1:0] instr;
        logic                 valid;
        logic                 stall;
        controls_t            exp;
    } entry_t;

    logic                 clk;
    logic                 rst;
    logic [DataWidth-1:0] instr;
    logic                 instrValid;
    logic                 stall;
    controls_t            controls;

    entry_t      entries[$];
    controls_t   lastExp;
    logic [31:0] rngState;
    int          numEntries;
    logic        tableReady;

    decodeStage dut (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .stall      (stall),
        .controls   (controls)
    );

    always #(ClkPeriod/2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic logic [31:0] signExtend(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic pushEntry(input logic [31:0] word, input logic valid, input logic hold,
                             input controls_t exp);
        entry_t en;
        en.instr = word;
        en.valid = valid;
        en.stall = hold;
        en.exp   = exp;
        entries.push_back(en);
        lastExp = exp; // a stalled entry repeats this
    endtask

    task automatic regAlu(input funct_e fn, input aluOp_e alu, input logic overflow);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.regRead1      = r[4:0];
        e.regRead2      = r[12:8];
        e.destReg       = r[20:16];
        e.aluOp         = alu;
        e.grfSrc        = grfAlu;
        e.checkOverflow = overflow;
        pushEntry({opSpecial, r[4:0], r[12:8], r[20:16], 5'd0, fn}, 1'b1, 1'b0, e);
    endtask

    task automatic constShift(input funct_e fn, input aluOp_e alu);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.regRead1  = r[12:8]; // rt is shifted
        e.destReg   = r[20:16];
        e.aluOp     = alu;
        e.aluSrc    = 1'b1;
        e.immediate = {27'd0, r[28:24]};
        e.grfSrc    = grfAlu;
        pushEntry({opSpecial, r[4:0], r[12:8], r[20:16], r[28:24], fn}, 1'b1, 1'b0, e);
    endtask

    task automatic varShift(input funct_e fn, input aluOp_e alu);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.regRead1 = r[12:8];
        e.regRead2 = r[4:0];
        e.destReg  = r[20:16];
        e.aluOp    = alu;
        e.grfSrc   = grfAlu;
        pushEntry({opSpecial, r[4:0], r[12:8], r[20:16], 5'd0, fn}, 1'b1, 1'b0, e);
    endtask

    task automatic jumpReg(input funct_e fn, input logic link);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.regRead1 = r[4:0];
        e.absJump  = 1'b1;
        e.jumpSrc  = jumpRegister;
        if (link)
        begin
            e.destReg = r[20:16];
            e.grfSrc  = grfPc;
        end
        pushEntry({opSpecial, r[4:0], r[12:8], r[20:16], 5'd0, fn}, 1'b1, 1'b0, e);
    endtask

    task automatic exceptionOnly(input funct_e fn, input exception_e exc);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.exception = exc;
        pushEntry({opSpecial, r[19:0], fn}, 1'b1, 1'b0, e); // random code field
    endtask

    task automatic immAlu(input primaryOp_e op, input aluOp_e alu, input logic overflow,
                          input int kind);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.regRead1      = r[4:0];
        e.destReg       = r[12:8];
        e.aluOp         = alu;
        e.aluSrc        = 1'b1;
        e.checkOverflow = overflow;
        e.grfSrc        = grfAlu;
        case (kind)
            ImmZero:  e.immediate = {16'd0, r[31:16]};
            ImmUpper: e.immediate = {r[31:16], 16'd0};
            default:  e.immediate = signExtend(r[31:16]);
        endcase
        pushEntry({op, r[4:0], r[12:8], r[31:16]}, 1'b1, 1'b0, e);
    endtask

    task automatic loadOp(input primaryOp_e op, input memWidth_e width, input logic sext);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.regRead1      = r[4:0];
        e.destReg       = r[12:8];
        e.aluOp         = aluAdd;
        e.immediate     = signExtend(r[31:16]);
        e.grfSrc        = grfMem;
        e.memLoad       = 1'b1;
        e.memWidth      = width;
        e.memSignExtend = sext;
        e.calcAddress   = 1'b1;
        pushEntry({op, r[4:0], r[12:8], r[31:16]}, 1'b1, 1'b0, e);
    endtask

    task automatic storeOp(input primaryOp_e op, input memWidth_e width);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.regRead1    = r[4:0];
        e.regRead2    = r[12:8];
        e.immediate   = signExtend(r[31:16]);
        e.memStore    = 1'b1;
        e.memWidth    = width;
        e.calcAddress = 1'b1;
        pushEntry({op, r[4:0], r[12:8], r[31:16]}, 1'b1, 1'b0, e);
    endtask

    task automatic condBranch(input primaryOp_e op, input cmpOp_e cmp, input logic readsRt);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.regRead1  = r[4:0];
        e.regRead2  = readsRt ? r[12:8] : 5'd0; // only beq and bne compare rt
        e.immediate = signExtend(r[31:16]);
        e.branch    = 1'b1;
        e.cmpOp     = cmp;
        pushEntry({op, r[4:0], r[12:8], r[31:16]}, 1'b1, 1'b0, e);
    endtask

    task automatic regimmBranch(input regimmOp_e code, input cmpOp_e cmp, input logic link);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.regRead1  = r[4:0];
        e.immediate = signExtend(r[31:16]);
        e.branch    = 1'b1;
        e.cmpOp     = cmp;
        if (link)
        begin
            e.destReg = 5'd31;
            e.grfSrc  = grfPc;
        end
        pushEntry({opRegimm, r[4:0], code, r[31:16]}, 1'b1, 1'b0, e);
    endtask

    task automatic absoluteJump(input primaryOp_e op, input logic link);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.immediate = {6'd0, r[25:0]};
        e.absJump   = 1'b1;
        e.jumpSrc   = jumpImmediate;
        if (link)
        begin
            e.destReg = 5'd31;
            e.grfSrc  = grfPc;
        end
        pushEntry({op, r[25:0]}, 1'b1, 1'b0, e);
    endtask

    // rs and bits 15:11 get random values, the rest stays as given
    task automatic unknownWord(input logic [31:0] word);
        logic [31:0] r;
        controls_t   e;
        r = nextRandom();
        e = NopControls;
        e.exception = excUnknownInstruction;
        pushEntry(word | {6'd0, r[4:0], 5'd0, r[20:16], 11'd0}, 1'b1, 1'b0, e);
    endtask

    task automatic bubble();
        logic [31:0] r;
        r = nextRandom();
        pushEntry({opSpecial, r[4:0], r[12:8], r[20:16], 5'd0, fnAddu}, 1'b0, 1'b0, NopControls);
    endtask

    task automatic stalledWord();
        logic [31:0] r;
        r = nextRandom();
        pushEntry({opSpecial, r[4:0], r[12:8], r[20:16], 5'd0, fnSubu}, 1'b1, 1'b1, lastExp);
    endtask

    task automatic buildTable();
        regAlu(fnAddu, aluAdd, 1'b0);
        regAlu(fnAdd, aluAdd, 1'b1);
        regAlu(fnSubu, aluSub, 1'b0);
        regAlu(fnSub, aluSub, 1'b1);
        regAlu(fnAnd, aluAnd, 1'b0);
        regAlu(fnOr, aluOr, 1'b0);
        regAlu(fnNor, aluNor, 1'b0);
        regAlu(fnXor, aluXor, 1'b0);
        regAlu(fnSlt, aluSlt, 1'b0);
        regAlu(fnSltu, aluSltu, 1'b0);
        constShift(fnSll, aluShiftLeft);
        constShift(fnSrl, aluShiftRight);
        constShift(fnSra, aluShiftArith);
        varShift(fnSllv, aluShiftLeft);
        varShift(fnSrlv, aluShiftRight);
        varShift(fnSrav, aluShiftArith);
        exceptionOnly(fnSyscall, excSyscall);
        exceptionOnly(fnBreak, excBreak);
        stalledWord();
        immAlu(opAddi, aluAdd, 1'b1, ImmSign);
        immAlu(opAddiu, aluAdd, 1'b0, ImmSign);
        immAlu(opSlti, aluSlt, 1'b0, ImmSign);
        immAlu(opSltiu, aluSltu, 1'b0, ImmSign);
        immAlu(opAndi, aluAnd, 1'b0, ImmZero);
        immAlu(opOri, aluOr, 1'b0, ImmZero);
        immAlu(opXori, aluXor, 1'b0, ImmZero);
        immAlu(opLui, aluAdd, 1'b0, ImmUpper);
        bubble();
        loadOp(opLb, memByte, 1'b1);
        loadOp(opLh, memHalf, 1'b1);
        loadOp(opLw, memWord, 1'b0);
        loadOp(opLbu, memByte, 1'b0);
        loadOp(opLhu, memHalf, 1'b0);
        storeOp(opSb, memByte);
        storeOp(opSh, memHalf);
        storeOp(opSw, memWord);
        stalledWord();
        stalledWord();
        condBranch(opBeq, cmpEqual, 1'b1);
        condBranch(opBne, cmpNotEqual, 1'b1);
        condBranch(opBlez, cmpLessEqualZero, 1'b0);
        condBranch(opBgtz, cmpGreaterZero, 1'b0);
        regimmBranch(riBltz, cmpLessZero, 1'b0);
        regimmBranch(riBgez, cmpGreaterEqualZero, 1'b0);
        regimmBranch(riBltzal, cmpLessZero, 1'b1);
        regimmBranch(riBgezal, cmpGreaterEqualZero, 1'b1);
        absoluteJump(opJ, 1'b0);
        absoluteJump(opJal, 1'b1);
        jumpReg(fnJr, 1'b0);
        jumpReg(fnJalr, 1'b1);
        unknownWord(32'h4000_0000); // mfc0
        unknownWord(32'h7000_0000); // madd
        unknownWord(32'h0000_0034); // teq
        unknownWord(32'h0408_0000); // tgei
        unknownWord(32'hC000_0000); // ll
        unknownWord(32'h8800_0000); // lwl
        unknownWord(32'h5000_0000); // beql
        unknownWord(32'h0402_0000); // bltzl
        unknownWord(32'h0000_0018); // mult
        unknownWord(32'h0000_0005); // unused funct
        unknownWord(32'hFC00_0000); // unused opcode
        bubble();
    endtask

    task automatic abortRun();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkException(input exception_e act, input exception_e exp,
                                  input string what);
        if (act !== exp)
        begin
            $display("ERR %0t: %s, field exception got %s expected %s",
                     $time, what, act.name(), exp.name());
            abortRun();
        end
    endtask

    task automatic checkControls(input controls_t act, input controls_t exp, input string what);
        string field;
        field = "";
        if (act.regRead1 !== exp.regRead1) field = "regRead1";
        else if (act.regRead2 !== exp.regRead2) field = "regRead2";
        else if (act.destReg !== exp.destReg) field = "destReg";
        else if (act.aluOp !== exp.aluOp) field = "aluOp";
        else if (act.aluSrc !== exp.aluSrc) field = "aluSrc";
        else if (act.immediate !== exp.immediate) field = "immediate";
        else if (act.checkOverflow !== exp.checkOverflow) field = "checkOverflow";
        else if (act.grfSrc !== exp.grfSrc) field = "grfSrc";
        else if (act.memLoad !== exp.memLoad) field = "memLoad";
        else if (act.memStore !== exp.memStore) field = "memStore";
        else if (act.memWidth !== exp.memWidth) field = "memWidth";
        else if (act.memSignExtend !== exp.memSignExtend) field = "memSignExtend";
        else if (act.calcAddress !== exp.calcAddress) field = "calcAddress";
        else if (act.branch !== exp.branch) field = "branch";
        else if (act.cmpOp !== exp.cmpOp) field = "cmpOp";
        else if (act.absJump !== exp.absJump) field = "absJump";
        else if (act.jumpSrc !== exp.jumpSrc) field = "jumpSrc";
        else if (act !== exp) field = "exception";
        if (field != "")
        begin
            $display("ERR %0t: %s, field %s got %h expected %h", $time, what, field, act, exp);
            abortRun();
        end
    endtask

    // watchdog, sized once the table exists
    initial
    begin
        wait (tableReady === 1'b1);
        #(ClkPeriod * (numEntries + 20));
        $display("timeout: decode stage run did not finish within %0d cycles", numEntries + 20);
        abortRun();
    end

    initial
    begin
        clk        = 1'b0;
        rst        <= 1'b1;
        instr      <= '0;
        instrValid <= 1'b0;
        stall      <= 1'b0;
        rngState   = 32'd20479;
        lastExp    = NopControls;
        buildTable();
        numEntries = entries.size();
        tableReady = 1'b1;

        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkException(controls.exception, excNone, "after reset");
        checkControls(controls, NopControls, "after reset");

        // entry i is driven while entry i-1 shows on controls
        for (int i = 0; i <= numEntries; i++)
        begin
            @(posedge clk);
            if (i < numEntries)
            begin
                instr      <= entries[i].instr;
                instrValid <= entries[i].valid;
                stall      <= entries[i].stall;
            end
            else
            begin
                instrValid <= 1'b0;
                stall      <= 1'b0;
            end
            if (i > 0)
            begin
                @(negedge clk);
                checkException(controls.exception, entries[i-1].exp.exception,
                               $sformatf("entry %0d", i - 1));
                checkControls(controls, entries[i-1].exp, $sformatf("entry %0d", i - 1));
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: decodeStage.f
logic/decodePkg.sv
logic/specialDecoder.sv
logic/immediateDecoder.sv
logic/branchDecoder.sv
logic/decodeStage.sv
testbench/decodeStage_checker.sv
testbench/decodeStage_tb.sv

// File: Makefile
VERILATOR = verilator
TOP       = decodeStage_tb
RTL_TOP   = decodeStage
FLIST     = decodeStage.f
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
